/* prf_cfg.svh */
`ifndef PRF_CFG_SVH
`define PRF_CFG_SVH

// physical register file geometry
`define PRF_ENTRIES 64
`define PREG_BITS 6
`define XLEN 32

// iterative multiplier, one step per multiplier bit
`define MDU_STEPS 32

// debug APB byte address
`define APB_ADDR_BITS 12

`endif

/* prf_pkg.sv */
`include "prf_cfg.svh"

package prf_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`PREG_BITS-1:0] preg_t;

    // must hold MDU_STEPS itself, not just MDU_STEPS-1
    typedef logic [$clog2(`MDU_STEPS + 1)-1:0] step_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4
    } alu_op_t;

    typedef enum logic [1:0] {
        dbg_idle      = 2'd0,
        dbg_read_wait = 2'd1,
        dbg_respond   = 2'd2
    } dbg_state_t;

endpackage

/* prf.sv */
`timescale 1ns/1ns
`include "prf_cfg.svh"

module prf (
    input  logic           clk,
    input  logic           rst,
    input  prf_pkg::preg_t alu0_rs0,
    input  prf_pkg::preg_t alu0_rs1,
    input  prf_pkg::preg_t alu1_rs0,
    input  prf_pkg::preg_t alu1_rs1,
    input  prf_pkg::preg_t mdu_rs0,
    input  prf_pkg::preg_t mdu_rs1,
    input  prf_pkg::preg_t dbg_rs,
    output prf_pkg::word_t alu0_rs0_data,
    output prf_pkg::word_t alu0_rs1_data,
    output prf_pkg::word_t alu1_rs0_data,
    output prf_pkg::word_t alu1_rs1_data,
    output prf_pkg::word_t mdu_rs0_data,
    output prf_pkg::word_t mdu_rs1_data,
    output prf_pkg::word_t dbg_rs_data,
    input  logic           alu0_wen,
    input  logic           alu1_wen,
    input  logic           mdu_wen,
    input  logic           dbg_wen,
    input  prf_pkg::preg_t alu0_wrd,
    input  prf_pkg::preg_t alu1_wrd,
    input  prf_pkg::preg_t mdu_wrd,
    input  prf_pkg::preg_t dbg_wrd,
    input  prf_pkg::word_t alu0_wdata,
    input  prf_pkg::word_t alu1_wdata,
    input  prf_pkg::word_t mdu_wdata,
    input  prf_pkg::word_t dbg_wdata
);
    import prf_pkg::*;

    localparam int N_BANKS = 4;
    localparam int N_READ  = 7;
    localparam int N_WB    = 4;

    // one bank per reading unit, all holding the same contents
    word_t bank [N_BANKS][`PRF_ENTRIES];

    logic [N_WB-1:0]    wb_wen;
    preg_t [N_WB-1:0]   wb_wrd;
    word_t [N_WB-1:0]   wb_wdata;
    preg_t [N_READ-1:0] rd_idx;
    word_t [N_READ-1:0] rd_data;

    ////////////////////
    // port gathering
    ////////////////////

    // index 0 is alu0, so lower index means higher bypass priority
    assign wb_wen   = {dbg_wen, mdu_wen, alu1_wen, alu0_wen};
    assign wb_wrd   = {dbg_wrd, mdu_wrd, alu1_wrd, alu0_wrd};
    assign wb_wdata = {dbg_wdata, mdu_wdata, alu1_wdata, alu0_wdata};

    // read port p is served by bank p/2
    assign rd_idx = {dbg_rs, mdu_rs1, mdu_rs0, alu1_rs1, alu1_rs0, alu0_rs1, alu0_rs0};
    assign {dbg_rs_data, mdu_rs1_data, mdu_rs0_data, alu1_rs1_data,
            alu1_rs0_data, alu0_rs1_data, alu0_rs0_data} = rd_data;

    ////////////////////
    // read with bypass
    ////////////////////

    always_comb begin
        for (int p = 0; p < N_READ; p++) begin
            rd_data[p] = bank[p / 2][rd_idx[p]];
            // walk lowest priority first so alu0 wins
            for (int w = N_WB - 1; w >= 0; w--) begin
                if (wb_wen[w] && wb_wrd[w] == rd_idx[p]) begin
                    rd_data[p] = wb_wdata[w];
                end
            end
            // p0 is hardwired zero
            if (rd_idx[p] == '0) begin
                rd_data[p] = '0;
            end
        end
    end

    ////////////////////
    // writeback
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < N_BANKS; b++) begin
                for (int i = 0; i < `PRF_ENTRIES; i++) begin
                    bank[b][i] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < N_WB; w++) begin
                if (wb_wen[w]) begin
                    for (int b = 0; b < N_BANKS; b++) begin
                        bank[b][wb_wrd[w]] <= wb_wdata[w];
                    end
                end
            end
        end
    end

endmodule

/* alu_unit.sv */
`timescale 1ns/1ns

module alu_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid,
    input  prf_pkg::alu_op_t op,
    input  prf_pkg::preg_t   rs0,
    input  prf_pkg::preg_t   rs1,
    input  prf_pkg::preg_t   rd,
    input  prf_pkg::word_t   rs0_data,
    input  prf_pkg::word_t   rs1_data,
    output prf_pkg::preg_t   rs0_addr,
    output prf_pkg::preg_t   rs1_addr,
    output logic             wen,
    output prf_pkg::preg_t   wrd,
    output prf_pkg::word_t   wdata
);
    import prf_pkg::*;

    word_t result;

    // operands come back from the PRF in the issue cycle
    assign rs0_addr = rs0;
    assign rs1_addr = rs1;

    always_comb begin
        case (op)
            alu_add: result = rs0_data + rs1_data;
            alu_sub: result = rs0_data - rs1_data;
            alu_and: result = rs0_data & rs1_data;
            alu_or:  result = rs0_data | rs1_data;
            alu_xor: result = rs0_data ^ rs1_data;
            default: result = '0;
        endcase
    end

    // one writeback cycle right after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            wen <= 1'b0;
        end else begin
            wen <= valid;
        end
    end

    always_ff @(posedge clk) begin
        wrd   <= rd;
        wdata <= result;
    end

endmodule

/* mdu_timer.sv */
`timescale 1ns/1ns
`include "prf_cfg.svh"

module mdu_timer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic busy,
    output logic last
);
    import prf_pkg::*;

    // steps still to run, zero when idle
    step_t count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= step_t'(`MDU_STEPS);
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);
    assign last = (count == step_t'(1));

endmodule

/* mdu_unit.sv */
`timescale 1ns/1ns

module mdu_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           valid,
    input  prf_pkg::preg_t rs0,
    input  prf_pkg::preg_t rs1,
    input  prf_pkg::preg_t rd,
    input  prf_pkg::word_t rs0_data,
    input  prf_pkg::word_t rs1_data,
    output prf_pkg::preg_t rs0_addr,
    output prf_pkg::preg_t rs1_addr,
    output logic           busy,
    output logic           wen,
    output prf_pkg::preg_t wrd,
    output prf_pkg::word_t wdata
);
    import prf_pkg::*;

    logic  start;
    logic  last;
    word_t mcand;
    word_t mplier;
    word_t acc;
    preg_t rd_q;

    assign rs0_addr = rs0;
    assign rs1_addr = rs1;

    // issues while busy are dropped
    assign start = valid && !busy;

    mdu_timer u_timer (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .last  (last)
    );

    ////////////////////
    // shift-add datapath
    ////////////////////

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= rs0_data;
            mplier <= rs1_data;
            acc    <= '0;
            rd_q   <= rd;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            // only the low word is kept, upper bits fall off
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // product is complete the cycle after the last step
    always_ff @(posedge clk) begin
        if (rst) begin
            wen <= 1'b0;
        end else begin
            wen <= last;
        end
    end

    assign wrd   = rd_q;
    assign wdata = acc;

endmodule

/* apb_prf_port.sv */
`timescale 1ns/1ns
`include "prf_cfg.svh"

module apb_prf_port (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`APB_ADDR_BITS-1:0] paddr,
    input  prf_pkg::word_t            pwdata,
    output prf_pkg::word_t            prdata,
    output logic                      pready,
    output logic                      pslverr,
    output prf_pkg::preg_t            rs,
    input  prf_pkg::word_t            rs_data,
    output logic                      wen,
    output prf_pkg::preg_t            wrd,
    output prf_pkg::word_t            wdata
);
    import prf_pkg::*;

    dbg_state_t state;
    word_t      rdata_q;
    preg_t      idx;
    logic       access;
    logic       addr_err;
    logic       fast_done;

    // word addressed, 64 regs fill bytes 0..255
    assign idx    = paddr[`PREG_BITS+1:2];
    assign access = psel && penable;

    // out of range, or a write to p0
    assign addr_err = (paddr[`APB_ADDR_BITS-1:`PREG_BITS+2] != '0) ||
                      (pwrite && idx == '0);

    // writes and errors finish in the first access cycle
    assign fast_done = (state == dbg_idle) && access && (pwrite || addr_err);

    ////////////////////
    // APB state machine
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dbg_idle;
        end else begin
            case (state)
                dbg_idle: begin
                    // good read seen in setup phase
                    if (psel && !penable && !pwrite && !addr_err) begin
                        state <= dbg_read_wait;
                    end
                end
                dbg_read_wait: begin
                    if (access) begin
                        state <= dbg_respond;
                    end
                end
                dbg_respond: begin
                    state <= dbg_idle;
                end
                default: begin
                    state <= dbg_idle;
                end
            endcase
        end
    end

    // wait state samples the PRF read port
    always_ff @(posedge clk) begin
        if (state == dbg_read_wait && access) begin
            rdata_q <= rs_data;
        end
    end

    assign pready  = fast_done || (state == dbg_respond);
    assign pslverr = fast_done && addr_err;
    assign prdata  = rdata_q;

    assign rs    = idx;
    assign wen   = fast_done && pwrite && !addr_err;
    assign wrd   = idx;
    assign wdata = pwdata;

endmodule

/* backend_top.sv */
`timescale 1ns/1ns
`include "prf_cfg.svh"

module backend_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alu0_valid,
    input  logic                      alu1_valid,
    input  prf_pkg::alu_op_t          alu0_op,
    input  prf_pkg::alu_op_t          alu1_op,
    input  prf_pkg::preg_t            alu0_rs0,
    input  prf_pkg::preg_t            alu0_rs1,
    input  prf_pkg::preg_t            alu0_rd,
    input  prf_pkg::preg_t            alu1_rs0,
    input  prf_pkg::preg_t            alu1_rs1,
    input  prf_pkg::preg_t            alu1_rd,
    input  logic                      mdu_valid,
    input  prf_pkg::preg_t            mdu_rs0,
    input  prf_pkg::preg_t            mdu_rs1,
    input  prf_pkg::preg_t            mdu_rd,
    output logic                      mdu_busy,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`APB_ADDR_BITS-1:0] paddr,
    input  prf_pkg::word_t            pwdata,
    output prf_pkg::word_t            prdata,
    output logic                      pready,
    output logic                      pslverr
);
    import prf_pkg::*;

    // read port indices and returned operands
    preg_t alu0_ra0, alu0_ra1, alu1_ra0, alu1_ra1, mdu_ra0, mdu_ra1, dbg_rs;
    word_t alu0_rs0_data, alu0_rs1_data, alu1_rs0_data, alu1_rs1_data;
    word_t mdu_rs0_data, mdu_rs1_data, dbg_rs_data;

    // writeback triples
    logic  alu0_wen, alu1_wen, mdu_wen, dbg_wen;
    preg_t alu0_wrd, alu1_wrd, mdu_wrd, dbg_wrd;
    word_t alu0_wdata, alu1_wdata, mdu_wdata, dbg_wdata;

    prf u_prf (
        .clk           (clk),
        .rst           (rst),
        .alu0_rs0      (alu0_ra0),
        .alu0_rs1      (alu0_ra1),
        .alu1_rs0      (alu1_ra0),
        .alu1_rs1      (alu1_ra1),
        .mdu_rs0       (mdu_ra0),
        .mdu_rs1       (mdu_ra1),
        .dbg_rs        (dbg_rs),
        .alu0_rs0_data (alu0_rs0_data),
        .alu0_rs1_data (alu0_rs1_data),
        .alu1_rs0_data (alu1_rs0_data),
        .alu1_rs1_data (alu1_rs1_data),
        .mdu_rs0_data  (mdu_rs0_data),
        .mdu_rs1_data  (mdu_rs1_data),
        .dbg_rs_data   (dbg_rs_data),
        .alu0_wen      (alu0_wen),
        .alu1_wen      (alu1_wen),
        .mdu_wen       (mdu_wen),
        .dbg_wen       (dbg_wen),
        .alu0_wrd      (alu0_wrd),
        .alu1_wrd      (alu1_wrd),
        .mdu_wrd       (mdu_wrd),
        .dbg_wrd       (dbg_wrd),
        .alu0_wdata    (alu0_wdata),
        .alu1_wdata    (alu1_wdata),
        .mdu_wdata     (mdu_wdata),
        .dbg_wdata     (dbg_wdata)
    );

    alu_unit u_alu0 (
        .clk      (clk),
        .rst      (rst),
        .valid    (alu0_valid),
        .op       (alu0_op),
        .rs0      (alu0_rs0),
        .rs1      (alu0_rs1),
        .rd       (alu0_rd),
        .rs0_data (alu0_rs0_data),
        .rs1_data (alu0_rs1_data),
        .rs0_addr (alu0_ra0),
        .rs1_addr (alu0_ra1),
        .wen      (alu0_wen),
        .wrd      (alu0_wrd),
        .wdata    (alu0_wdata)
    );

    alu_unit u_alu1 (
        .clk      (clk),
        .rst      (rst),
        .valid    (alu1_valid),
        .op       (alu1_op),
        .rs0      (alu1_rs0),
        .rs1      (alu1_rs1),
        .rd       (alu1_rd),
        .rs0_data (alu1_rs0_data),
        .rs1_data (alu1_rs1_data),
        .rs0_addr (alu1_ra0),
        .rs1_addr (alu1_ra1),
        .wen      (alu1_wen),
        .wrd      (alu1_wrd),
        .wdata    (alu1_wdata)
    );

    mdu_unit u_mdu (
        .clk      (clk),
        .rst      (rst),
        .valid    (mdu_valid),
        .rs0      (mdu_rs0),
        .rs1      (mdu_rs1),
        .rd       (mdu_rd),
        .rs0_data (mdu_rs0_data),
        .rs1_data (mdu_rs1_data),
        .rs0_addr (mdu_ra0),
        .rs1_addr (mdu_ra1),
        .busy     (mdu_busy),
        .wen      (mdu_wen),
        .wrd      (mdu_wrd),
        .wdata    (mdu_wdata)
    );

    apb_prf_port u_apb (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .rs      (dbg_rs),
        .rs_data (dbg_rs_data),
        .wen     (dbg_wen),
        .wrd     (dbg_wrd),
        .wdata   (dbg_wdata)
    );

endmodule

/* backend_sva.sv */
`timescale 1ns/1ns
`include "prf_cfg.svh"

module backend_sva (
    input logic           clk,
    input logic           rst,
    input logic           psel,
    input logic           penable,
    input logic           pready,
    input logic           alu0_wen,
    input logic           alu1_wen,
    input logic           mdu_wen,
    input logic           dbg_wen,
    input prf_pkg::preg_t alu0_wrd,
    input prf_pkg::preg_t alu1_wrd,
    input prf_pkg::preg_t mdu_wrd,
    input prf_pkg::preg_t dbg_wrd,
    input logic           mdu_busy
);
    import prf_pkg::*;

    // length of the current busy stretch
    int busy_len;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_len <= 0;
        end else if (mdu_busy) begin
            busy_len <= busy_len + 1;
        end else begin
            busy_len <= 0;
        end
    end

    ////////////////////
    // APB
    ////////////////////

    pready_in_access: assert property (@(posedge clk) disable iff (rst)
        pready |-> (psel && penable))
        else $error("pready raised outside an APB access phase");

    ////////////////////
    // writeback
    ////////////////////

    no_p0_write: assert property (@(posedge clk) disable iff (rst)
        !((alu0_wen && alu0_wrd == '0) || (alu1_wen && alu1_wrd == '0) ||
          (mdu_wen && mdu_wrd == '0) || (dbg_wen && dbg_wrd == '0)))
        else $error("writeback targets physical register 0");

    mdu_wen_at_fall: assert property (@(posedge clk) disable iff (rst)
        mdu_wen |-> $fell(mdu_busy))
        else $error("MDU writeback without busy falling");

    busy_length: assert property (@(posedge clk) disable iff (rst)
        $fell(mdu_busy) |-> (busy_len == `MDU_STEPS))
        else $error("MDU busy stretch differs from the step count");

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* backend_tb.sv */
`timescale 1ns/1ns
`include "prf_cfg.svh"

module backend_tb;
    import prf_pkg::*;

    // full run needs about 1200 cycles, limit leaves ample margin
    localparam int TIMEOUT_CYCLES = 5000;
    localparam logic [31:0] LFSR_SEED = 32'hdb1f_42ae;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic clk, rst;
    logic alu0_valid, alu1_valid, mdu_valid;
    alu_op_t alu0_op, alu1_op;
    preg_t alu0_rs0, alu0_rs1, alu0_rd, alu1_rs0, alu1_rs1, alu1_rd;
    preg_t mdu_rs0, mdu_rs1, mdu_rd;
    logic mdu_busy;
    logic psel, penable, pwrite;
    logic [`APB_ADDR_BITS-1:0] paddr;
    word_t pwdata, prdata;
    logic pready, pslverr;

    logic [31:0] lfsr;
    word_t model [`PRF_ENTRIES];
    int cycles = 0;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    backend_top uut (
        .clk        (clk),
        .rst        (rst),
        .alu0_valid (alu0_valid),
        .alu1_valid (alu1_valid),
        .alu0_op    (alu0_op),
        .alu1_op    (alu1_op),
        .alu0_rs0   (alu0_rs0),
        .alu0_rs1   (alu0_rs1),
        .alu0_rd    (alu0_rd),
        .alu1_rs0   (alu1_rs0),
        .alu1_rs1   (alu1_rs1),
        .alu1_rd    (alu1_rd),
        .mdu_valid  (mdu_valid),
        .mdu_rs0    (mdu_rs0),
        .mdu_rs1    (mdu_rs1),
        .mdu_rd     (mdu_rd),
        .mdu_busy   (mdu_busy),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

    bind backend_top backend_sva u_sva (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pready   (pready),
        .alu0_wen (alu0_wen),
        .alu1_wen (alu1_wen),
        .mdu_wen  (mdu_wen),
        .dbg_wen  (dbg_wen),
        .alu0_wrd (alu0_wrd),
        .alu1_wrd (alu1_wrd),
        .mdu_wrd  (mdu_wrd),
        .dbg_wrd  (dbg_wrd),
        .mdu_busy (mdu_busy)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Simulation finished: FAIL");
            $fatal(1, "run aborted on timeout");
        end
    end

    ////////////////////
    // checking helpers
    ////////////////////

    task automatic report_mismatch(input string test, input word_t expected,
                                   input word_t actual);
        $display("ERROR %s: expected %h, actual %h", test, expected, actual);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_word(input string test, input word_t expected, input word_t actual);
        assert (actual === expected) else report_mismatch(test, expected, actual);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit
    task automatic random_word(output word_t value);
        value = '0;
        for (int i = 0; i < `XLEN; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[`XLEN-2:0], lfsr[0]};
        end
    endtask

    function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            default: return a ^ b;
        endcase
    endfunction

    function automatic logic [`APB_ADDR_BITS-1:0] reg_addr(input preg_t r);
        return {{(`APB_ADDR_BITS - `PREG_BITS - 2){1'b0}}, r, 2'b00};
    endfunction

    ////////////////////
    // APB driver
    ////////////////////

    task automatic apb_write(input logic [`APB_ADDR_BITS-1:0] addr, input word_t data,
                             output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        err = pslverr;
        // writes complete without a wait state
        check_word("apb_write wait states", '0, word_t'(waits));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [`APB_ADDR_BITS-1:0] addr, output word_t data,
                            output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        data = prdata;
        err  = pslverr;
        // in-range reads take one wait state
        if (addr < 12'h100) begin
            check_word("apb_read wait states", 32'd1, word_t'(waits));
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic load_reg(input preg_t r, input word_t value);
        logic err;
        apb_write(reg_addr(r), value, err);
        check_word("load_reg pslverr", '0, word_t'(err));
        model[r] = value;
    endtask

    task automatic expect_reg(input string test, input preg_t r, input word_t expected);
        word_t data;
        logic err;
        apb_read(reg_addr(r), data, err);
        check_word(test, '0, word_t'(err));
        check_word(test, expected, data);
    endtask

    ////////////////////
    // unit drive
    ////////////////////

    task automatic drive_alu0(input alu_op_t op, input preg_t rs0, input preg_t rs1,
                              input preg_t rd);
        alu0_valid <= 1'b1;
        alu0_op    <= op;
        alu0_rs0   <= rs0;
        alu0_rs1   <= rs1;
        alu0_rd    <= rd;
    endtask

    task automatic drive_alu1(input alu_op_t op, input preg_t rs0, input preg_t rs1,
                              input preg_t rd);
        alu1_valid <= 1'b1;
        alu1_op    <= op;
        alu1_rs0   <= rs0;
        alu1_rs1   <= rs1;
        alu1_rd    <= rd;
    endtask

    task automatic alu_idle();
        alu0_valid <= 1'b0;
        alu1_valid <= 1'b0;
    endtask

    task automatic drive_mdu(input preg_t rs0, input preg_t rs1, input preg_t rd);
        mdu_valid <= 1'b1;
        mdu_rs0   <= rs0;
        mdu_rs1   <= rs1;
        mdu_rd    <= rd;
    endtask

    task automatic wait_mdu_idle();
        @(negedge clk);
        while (mdu_busy) begin
            @(negedge clk);
        end
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic test_reset_state();
        for (int r = 0; r < `PRF_ENTRIES; r++) begin
            expect_reg("reset_state", preg_t'(r), '0);
            model[r] = '0;
        end
    endtask

    task automatic test_apb_access();
        word_t value;
        word_t data;
        logic err;
        for (int r = 1; r < `PRF_ENTRIES; r++) begin
            random_word(value);
            load_reg(preg_t'(r), value);
        end
        for (int r = 1; r < `PRF_ENTRIES; r++) begin
            expect_reg("apb_readback", preg_t'(r), model[r]);
        end
        // p0 is read only
        apb_write(reg_addr('0), 32'hffff_ffff, err);
        check_word("apb_write_p0 pslverr", 32'd1, word_t'(err));
        expect_reg("apb_write_p0", '0, '0);
        // 0x104 would alias p1 if the upper bits were ignored
        apb_write(12'h104, ~model[1], err);
        check_word("apb_range_write pslverr", 32'd1, word_t'(err));
        apb_read(12'hffc, data, err);
        check_word("apb_range_read pslverr", 32'd1, word_t'(err));
        expect_reg("apb_range_write", 6'd1, model[1]);
    endtask

    task automatic test_alu_ops();
        alu_op_t ops [5] = '{alu_add, alu_sub, alu_and, alu_or, alu_xor};
        word_t value;
        for (int r = 1; r <= 4; r++) begin
            random_word(value);
            load_reg(preg_t'(r), value);
        end
        for (int k = 0; k < 5; k++) begin
            @(posedge clk);
            drive_alu0(ops[k], 6'd1, 6'd2, preg_t'(10 + k));
            drive_alu1(ops[k], 6'd3, 6'd4, preg_t'(20 + k));
            @(posedge clk);
            alu_idle();
            model[10 + k] = alu_model(ops[k], model[1], model[2]);
            model[20 + k] = alu_model(ops[k], model[3], model[4]);
        end
        for (int k = 0; k < 5; k++) begin
            expect_reg("alu0_ops", preg_t'(10 + k), model[10 + k]);
            expect_reg("alu1_ops", preg_t'(20 + k), model[20 + k]);
        end
    endtask

    task automatic test_bypass_chain();
        word_t value;
        for (int r = 5; r <= 7; r++) begin
            random_word(value);
            load_reg(preg_t'(r), value);
        end
        // each issue uses the previous result in the very next cycle
        @(posedge clk);
        drive_alu0(alu_add, 6'd5, 6'd6, 6'd30);
        @(posedge clk);
        alu_idle();
        drive_alu1(alu_sub, 6'd30, 6'd7, 6'd31);
        @(posedge clk);
        alu_idle();
        drive_alu0(alu_xor, 6'd31, 6'd5, 6'd32);
        drive_alu1(alu_add, 6'd0, 6'd0, 6'd33);
        @(posedge clk);
        alu_idle();
        drive_alu0(alu_and, 6'd6, 6'd0, 6'd34);
        @(posedge clk);
        alu_idle();
        model[30] = model[5] + model[6];
        model[31] = model[30] - model[7];
        model[32] = model[31] ^ model[5];
        expect_reg("bypass_alu0", 6'd30, model[30]);
        expect_reg("bypass_alu1", 6'd31, model[31]);
        expect_reg("bypass_chain", 6'd32, model[32]);
        expect_reg("bypass_p0_add", 6'd33, '0);
        expect_reg("bypass_p0_and", 6'd34, '0);
    endtask

    task automatic test_mdu();
        word_t value;
        int busy_cycles;
        for (int r = 40; r <= 42; r++) begin
            random_word(value);
            load_reg(preg_t'(r), value);
        end
        random_word(value);
        load_reg(6'd8, value);
        random_word(value);
        load_reg(6'd9, value);
        wait_mdu_idle();
        @(posedge clk);
        drive_mdu(6'd8, 6'd9, 6'd40);
        @(posedge clk);
        mdu_valid <= 1'b0;
        busy_cycles = 0;
        @(negedge clk);
        while (mdu_busy) begin
            busy_cycles++;
            @(negedge clk);
        end
        check_word("mdu_busy_length", word_t'(`MDU_STEPS), word_t'(busy_cycles));
        expect_reg("mdu_product", 6'd40, model[8] * model[9]);

        // second issue lands mid multiply and must be dropped
        @(posedge clk);
        drive_mdu(6'd9, 6'd8, 6'd42);
        @(posedge clk);
        mdu_valid <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_word("mdu_busy_at_second_issue", 32'd1, word_t'(mdu_busy));
        @(posedge clk);
        drive_mdu(6'd8, 6'd8, 6'd41);
        @(posedge clk);
        mdu_valid <= 1'b0;
        wait_mdu_idle();
        expect_reg("mdu_swapped_product", 6'd42, model[8] * model[9]);
        expect_reg("mdu_issue_while_busy", 6'd41, model[41]);
    endtask

    initial begin
        lfsr        = LFSR_SEED;
        alu0_valid  = 1'b0;
        alu1_valid  = 1'b0;
        alu0_op     = alu_add;
        alu1_op     = alu_add;
        alu0_rs0    = '0;
        alu0_rs1    = '0;
        alu0_rd     = '0;
        alu1_rs0    = '0;
        alu1_rs1    = '0;
        alu1_rd     = '0;
        mdu_valid   = 1'b0;
        mdu_rs0     = '0;
        mdu_rs1     = '0;
        mdu_rd      = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;

        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end

        test_reset_state();
        test_apb_access();
        test_alu_ops();
        test_bypass_chain();
        test_mdu();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
prf_pkg.sv
prf.sv
alu_unit.sv
mdu_timer.sv
mdu_unit.sv
apb_prf_port.sv
backend_top.sv
backend_sva.sv
tb_clock_gen.sv
backend_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f all.f --top-module backend_tb -o backend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/backend_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$log"; then
    exit 0
fi
exit 1
